//--- Makefile
# Verilator build and run for the garfield testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= garfield_tb
FILELIST  ?= garfield_top.f
OBJ_DIR   ?= obj_dir
SIMFLAGS  ?= +verilator+error+limit+1000
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/garfield_assert.sv
// garfield bound checks
`timescale 1ns/10ps
`default_nettype none

module garfield_assert #(
  parameter int DEBOUNCE_CYCLES  = 16,
  parameter int HEARTBEAT_CYCLES = 20,
  parameter int PWM_PERIOD       = 10
) (
  input logic                                 fpga_clk_50,
  input logic                                 hps_fpga_reset_n,
  input logic [garfield_pkg::apb_addr_w-1:0]  paddr,
  input logic                                 psel,
  input logic                                 penable,
  input logic                                 pwrite,
  input logic [garfield_pkg::apb_data_w-1:0]  pwdata,
  input logic [garfield_pkg::pwm_w-1:0]       drive_duty,
  input logic [garfield_pkg::pwm_w-1:0]       steer_duty,
  input logic                                 drive_pwm,
  input logic                                 steering_pwm,
  input logic [garfield_pkg::light_w-1:0]     lighting,
  input logic [garfield_pkg::led_w:0]         led,
  input logic [garfield_pkg::reset_req_w-1:0] reset_req,
  input logic                                 hps_cold_reset,
  input logic                                 hps_warm_reset,
  input logic                                 hps_debug_reset,
  input logic [garfield_pkg::key_w-1:0]       key,
  input logic [garfield_pkg::key_w-1:0]       keys_db
);
  import garfield_pkg::*;

  int fail_cnt = 0;  // failed assertion count

  logic [1:0]             pwm_out;
  logic [1:0][pwm_w-1:0]  duty;
  logic [reset_req_w-1:0] pulse;
  logic                   apb_wr;  // write in its access cycle

  assign pwm_out = {steering_pwm, drive_pwm};
  assign duty    = {steer_duty, drive_duty};
  assign pulse   = {hps_debug_reset, hps_warm_reset, hps_cold_reset};
  assign apb_wr  = psel & penable & pwrite;

  // ====================================================================
  // servo pwm high time over any frame window
  // ====================================================================
  for (genvar c = 0; c < 2; c++)
  begin : g_pwm
    logic [PWM_PERIOD-1:0] hist;    // last frame of output samples
    logic [pwm_w-1:0]      duty_q;
    int                    stable;  // clocks the duty has held
    int                    high_exp;

    // duty at or above the period saturates
    assign high_exp = (32'(duty[c]) >= PWM_PERIOD) ? PWM_PERIOD : 32'(duty[c]);

    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
      if (!hps_fpga_reset_n)
      begin
        hist   <= '0;
        duty_q <= '0;
        stable <= 0;
      end
      else
      begin
        hist   <= {hist[PWM_PERIOD-2:0], pwm_out[c]};
        duty_q <= duty[c];
        if (duty[c] != duty_q)
          stable <= 0;                 // new duty restarts the window
        else if (stable <= PWM_PERIOD + 1)
          stable <= stable + 1;
      end
    end

    assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
      (stable > PWM_PERIOD && duty[c] == duty_q) |-> $countones(hist) == high_exp)
    else
    begin
      fail_cnt++;
      $error("pwm channel %0d high time does not match its duty", c);
    end

    assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
      ($past(duty[c]) == '0) |-> !pwm_out[c])
    else
    begin
      fail_cnt++;
      $error("pwm channel %0d is high with zero duty", c);
    end
  end

  // hps reset pulses
  for (genvar b = 0; b < reset_req_w; b++)
  begin : g_pulse
    localparam int len = (b == 0) ? cold_pulse_cycles :
                         (b == 1) ? warm_pulse_cycles : debug_pulse_cycles;
    int high_cnt;  // clocks high so far

    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
      if (!hps_fpga_reset_n)
        high_cnt <= 0;
      else if (pulse[b])
        high_cnt <= high_cnt + 1;
      else
        high_cnt <= 0;
    end

    assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
      ($rose(reset_req[b]) && !pulse[b]) |=> pulse[b])
    else
    begin
      fail_cnt++;
      $error("reset pulse %0d did not start one clock after its request", b);
    end

    assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
      $fell(pulse[b]) |-> high_cnt == len)
    else
    begin
      fail_cnt++;
      $error("reset pulse %0d lasted %0d clocks instead of %0d", b, high_cnt, len);
    end
  end

  // ====================================================================
  // debounced keys only follow a steady input
  // ====================================================================
  for (genvar k = 0; k < key_w; k++)
  begin : g_key
    logic key_q;
    int   steady;  // clocks the raw key held its level

    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
      if (!hps_fpga_reset_n)
      begin
        key_q  <= 1'b1;
        steady <= 0;
      end
      else
      begin
        key_q <= key[k];
        if (key[k] != key_q)
          steady <= 1;
        else if (steady < DEBOUNCE_CYCLES)
          steady <= steady + 1;
      end
    end

    assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
      $changed(keys_db[k]) |-> (steady >= DEBOUNCE_CYCLES && keys_db[k] == key_q))
    else
    begin
      fail_cnt++;
      $error("key %0d changed before its input was steady", k);
    end
  end

  // lamps show written bits two clocks after the write edge
  assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    $past(apb_wr && paddr == reg_light) |=> lighting == $past(pwdata[light_w-1:0], 2))
  else
  begin
    fail_cnt++;
    $error("lighting outputs differ from the written lighting bits");
  end

  // leds show written pattern right after the write edge
  assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    (apb_wr && paddr == reg_led) |=> led[led_w:1] == $past(pwdata[led_w-1:0]))
  else
  begin
    fail_cnt++;
    $error("board leds differ from the written led pattern");
  end

  // heartbeat
  logic hb_q;
  int   hb_gap;  // clocks since the last toggle

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      hb_q   <= 1'b0;
      hb_gap <= 0;
    end
    else
    begin
      hb_q <= led[0];
      if (led[0] != hb_q)
        hb_gap <= 1;
      else
        hb_gap <= hb_gap + 1;
    end
  end

  assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    $changed(led[0]) |-> hb_gap == HEARTBEAT_CYCLES)
  else
  begin
    fail_cnt++;
    $error("heartbeat toggled after %0d clocks", hb_gap);
  end

  assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    hb_gap <= HEARTBEAT_CYCLES)
  else
  begin
    fail_cnt++;
    $error("heartbeat stopped toggling");
  end

endmodule

bind garfield_top garfield_assert #(
  .DEBOUNCE_CYCLES  (DEBOUNCE_CYCLES),
  .HEARTBEAT_CYCLES (HEARTBEAT_CYCLES),
  .PWM_PERIOD       (PWM_PERIOD)
) assert_i (
  .fpga_clk_50      (fpga_clk_50),
  .hps_fpga_reset_n (hps_fpga_reset_n),
  .paddr            (paddr),
  .psel             (psel),
  .penable          (penable),
  .pwrite           (pwrite),
  .pwdata           (pwdata),
  .drive_duty       (ctrl_if.drive_duty),
  .steer_duty       (ctrl_if.steer_duty),
  .drive_pwm        (drive_pwm),
  .steering_pwm     (steering_pwm),
  .lighting         (lighting),
  .led              (led),
  .reset_req        (ctrl_if.reset_req),
  .hps_cold_reset   (hps_cold_reset),
  .hps_warm_reset   (hps_warm_reset),
  .hps_debug_reset  (hps_debug_reset),
  .key              (key),
  .keys_db          (keys_db)
);

`default_nettype wire

//--- dv/garfield_tb.sv
// garfield top testbench
`timescale 1ns/10ps
`default_nettype none

module garfield_tb;
  import garfield_pkg::*;

  localparam int deb_cycles = 16;
  localparam int hb_cycles  = 20;
  localparam int pwm_period = 10;
  localparam int seed       = 33884;
  localparam logic [apb_addr_w-1:0] unmapped_addr = 8'h18;  // hole past the map

  logic                   fpga_clk_50;
  logic                   hps_fpga_reset_n;
  logic [apb_addr_w-1:0]  paddr;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [apb_data_w-1:0]  pwdata;
  logic [apb_data_w-1:0]  prdata;
  logic                   pslverr;
  logic [key_w-1:0]       key;
  logic [sw_w-1:0]        sw;
  logic                   drive_pwm;
  logic                   steering_pwm;
  logic [light_w-1:0]     lighting;
  logic [led_w:0]         led;
  logic                   hps_cold_reset;
  logic                   hps_warm_reset;
  logic                   hps_debug_reset;

  int tb_errors  = 0;  // readback and timeout failures
  int err_base   = 0;  // error total at test start
  int tests_run  = 0;
  int tests_bad  = 0;

  garfield_top #(
    .DEBOUNCE_CYCLES  (deb_cycles),
    .HEARTBEAT_CYCLES (hb_cycles),
    .PWM_PERIOD       (pwm_period)
  ) dut_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .paddr            (paddr),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .pwdata           (pwdata),
    .prdata           (prdata),
    .pslverr          (pslverr),
    .key              (key),
    .sw               (sw),
    .drive_pwm        (drive_pwm),
    .steering_pwm     (steering_pwm),
    .lighting         (lighting),
    .led              (led),
    .hps_cold_reset   (hps_cold_reset),
    .hps_warm_reset   (hps_warm_reset),
    .hps_debug_reset  (hps_debug_reset)
  );

  // 8 ns clock
  initial
  begin
    fpga_clk_50 = 1'b0;
    forever #4 fpga_clk_50 = ~fpga_clk_50;
  end

  // whole-run limit
  initial
  begin
    #200000;
    $display("timeout: simulation did not finish within 200 us");
    $display("Some tests failed");
    $finish;
  end

  // ====================================================================
  // helpers
  // ====================================================================
  function automatic int total_errors();
    return tb_errors + dut_i.assert_i.fail_cnt;  // own checks plus assertions
  endfunction

  function automatic logic [31:0] width_mask(input int w);
    return (32'h1 << w) - 32'h1;
  endfunction

  function automatic logic pulse_level(input int b);
    logic [2:0] p;
    p = {hps_debug_reset, hps_warm_reset, hps_cold_reset};
    return p[b];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      tb_errors++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic wait_clocks(input int n);
    repeat (n) @(posedge fpga_clk_50);
  endtask

  // setup, access, then release on the closing edge
  task automatic apb_write(input logic [apb_addr_w-1:0] addr, input logic [31:0] data,
                           output logic err);
    @(posedge fpga_clk_50);
    paddr   <= addr;
    pwdata  <= data;
    pwrite  <= 1'b1;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge fpga_clk_50);
    penable <= 1'b1;
    @(negedge fpga_clk_50);
    err = pslverr;
    @(posedge fpga_clk_50);   // write lands here
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [apb_addr_w-1:0] addr, output logic [31:0] data,
                          output logic err);
    @(posedge fpga_clk_50);
    paddr   <= addr;
    pwrite  <= 1'b0;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge fpga_clk_50);
    penable <= 1'b1;
    @(negedge fpga_clk_50);   // mid access cycle
    data = prdata;
    err  = pslverr;
    @(posedge fpga_clk_50);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic wait_pulse(input int b, input logic level, input int limit);
    int n;
    n = 0;
    do
    begin
      @(negedge fpga_clk_50);
      n++;
    end
    while (pulse_level(b) !== level && n < limit);
    if (pulse_level(b) !== level)
    begin
      tb_errors++;
      $display("reset pulse %0d did not reach level %0b within %0d clocks", b, level, limit);
    end
    @(posedge fpga_clk_50);   // back on the driving edge
  endtask

  task automatic wait_heartbeat(input int limit);
    logic start;
    int   n;
    @(negedge fpga_clk_50);
    start = led[0];
    n     = 0;
    do
    begin
      @(negedge fpga_clk_50);
      n++;
    end
    while (led[0] === start && n < limit);
    if (led[0] === start)
    begin
      tb_errors++;
      $display("heartbeat led did not toggle within %0d clocks", limit);
    end
    @(posedge fpga_clk_50);
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = total_errors() - err_base;
    tests_run++;
    if (errs == 0)
      $display("test %s: ok", name);
    else
    begin
      tests_bad++;
      $display("test %s: %0d errors", name, errs);
    end
    err_base = total_errors();
  endtask

  // ====================================================================
  // stimulus
  // ====================================================================
  initial
  begin
    logic [31:0] rd;
    logic [31:0] val;
    logic        err;
    int          drive_set [4];
    int          steer_set [4];

    void'($urandom(seed));
    paddr            = '0;
    psel             = 1'b0;
    penable          = 1'b0;
    pwrite           = 1'b0;
    pwdata           = '0;
    key              = '1;          // released, active low
    sw               = 4'($urandom());
    hps_fpga_reset_n = 1'b0;
    wait_clocks(4);
    hps_fpga_reset_n <= 1'b1;
    wait_clocks(2);

    // register readback, truncated to field widths
    val = $urandom();
    apb_write(reg_drive, val, err);
    apb_read(reg_drive, rd, err);
    check_value("prdata drive", rd, val & width_mask(pwm_w));
    val = $urandom();
    apb_write(reg_steer, val, err);
    apb_read(reg_steer, rd, err);
    check_value("prdata steer", rd, val & width_mask(pwm_w));
    val = $urandom();
    apb_write(reg_light, val, err);
    apb_read(reg_light, rd, err);
    check_value("prdata light", rd, val & width_mask(light_w));
    val = $urandom();
    apb_write(reg_led, val, err);
    apb_read(reg_led, rd, err);
    check_value("prdata led", rd, val & width_mask(led_w));
    apb_write(reg_status, 32'hffff_ffff, err);
    check_value("pslverr status write", 32'(err), 32'h1);
    apb_read(reg_status, rd, err);
    check_value("prdata status", rd, 32'({sw, 2'b11}));
    apb_read(unmapped_addr, rd, err);
    check_value("pslverr unmapped", 32'(err), 32'h1);
    check_value("prdata unmapped", rd, 32'h0);
    end_test("register readback");

    // lamps and leds follow the registers
    apb_write(reg_light, $urandom(), err);
    apb_write(reg_led, $urandom(), err);
    wait_clocks(4);
    apb_write(reg_light, 32'h0, err);
    wait_clocks(4);
    end_test("lighting and leds");

    // duties below, at and past the period
    drive_set[0] = 0;
    drive_set[1] = 1 + $urandom_range(pwm_period - 2);
    drive_set[2] = pwm_period;
    drive_set[3] = 16'hffff;
    steer_set[0] = 1 + $urandom_range(pwm_period - 2);
    steer_set[1] = 0;
    steer_set[2] = pwm_period + 2;
    steer_set[3] = 3;
    for (int i = 0; i < 4; i++)
    begin
      apb_write(reg_drive, 32'(drive_set[i]), err);
      apb_write(reg_steer, 32'(steer_set[i]), err);
      wait_clocks(3 * pwm_period);
    end
    end_test("pwm duty");

    // one pulse per request bit
    for (int b = 0; b < reset_req_w; b++)
    begin
      apb_write(reg_reset_req, 32'h1 << b, err);
      wait_pulse(b, 1'b1, 8);
      apb_write(reg_reset_req, 32'h0, err);
      wait_pulse(b, 1'b0, 64);
    end
    // second debug edge lands inside the pulse
    apb_write(reg_reset_req, 32'h4, err);
    wait_pulse(2, 1'b1, 8);
    apb_write(reg_reset_req, 32'h0, err);
    apb_write(reg_reset_req, 32'h4, err);
    apb_write(reg_reset_req, 32'h0, err);
    wait_pulse(2, 1'b0, 64);
    wait_clocks(4);
    end_test("reset pulses");

    // short glitch is filtered, long press shows up
    key[0] <= 1'b0;
    wait_clocks(deb_cycles - 4);
    key[0] <= 1'b1;
    wait_clocks(deb_cycles + 4);
    apb_read(reg_status, rd, err);
    check_value("prdata status after glitch", rd, 32'({sw, 2'b11}));
    key[1] <= 1'b0;
    wait_clocks(deb_cycles + 4);
    apb_read(reg_status, rd, err);
    check_value("prdata status key pressed", rd, 32'({sw, 2'b01}));
    key[1] <= 1'b1;
    wait_clocks(deb_cycles + 4);
    apb_read(reg_status, rd, err);
    check_value("prdata status key released", rd, 32'({sw, 2'b11}));
    end_test("key debounce");

    wait_heartbeat(hb_cycles + 2);
    wait_heartbeat(hb_cycles + 2);
    wait_clocks(2);
    end_test("heartbeat");

    $display("summary: %0d tests run, %0d with errors, %0d errors total",
             tests_run, tests_bad, total_errors());
    if (total_errors() == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- garfield_top.f
verilog/garfield_pkg.sv
verilog/vehicle_ctrl_if.sv
verilog/apb_regs.sv
verilog/key_debounce.sv
verilog/reset_pulse_gen.sv
verilog/servo_pwm.sv
verilog/status_led_driver.sv
verilog/garfield_top.sv
dv/garfield_assert.sv
dv/garfield_tb.sv

//--- verilog/apb_regs.sv
// apb control and status registers
`timescale 1ns/10ps
`default_nettype none

module apb_regs (
  input  logic                                fpga_clk_50,
  input  logic                                hps_fpga_reset_n,
  input  logic [garfield_pkg::apb_addr_w-1:0] paddr,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [garfield_pkg::apb_data_w-1:0] pwdata,
  input  logic [garfield_pkg::key_w-1:0]      keys_db,
  input  logic [garfield_pkg::sw_w-1:0]       sw,
  output logic [garfield_pkg::apb_data_w-1:0] prdata,
  output logic                                pslverr,
  vehicle_ctrl_if.regs                        ctrl
);
  import garfield_pkg::*;

  reg_addr_e              addr;
  logic                   access;   // access phase, no wait states
  logic                   mapped;   // paddr hits the map
  logic                   wr_ok;
  logic [apb_data_w-1:0]  rd_data;

  // stored register contents
  logic [pwm_w-1:0]       drive_q;
  logic [pwm_w-1:0]       steer_q;
  logic [light_w-1:0]     light_q;
  logic [led_w-1:0]       led_q;
  logic [reset_req_w-1:0] reset_req_q;

  assign addr   = reg_addr_e'(paddr);
  assign access = psel & penable;

  // read mux and decode
  always_comb
  begin
    rd_data = '0;  // unused bits read zero
    mapped  = 1'b1;
    case (addr)
      reg_drive:     rd_data[pwm_w-1:0]       = drive_q;
      reg_steer:     rd_data[pwm_w-1:0]       = steer_q;
      reg_light:     rd_data[light_w-1:0]     = light_q;
      reg_led:       rd_data[led_w-1:0]       = led_q;
      reg_status:    rd_data[sw_w+key_w-1:0]  = {sw, keys_db};
      reg_reset_req: rd_data[reset_req_w-1:0] = reset_req_q;
      default:       mapped = 1'b0;            // hole in the map
    endcase
  end

  // status is read only
  assign wr_ok   = access & pwrite & mapped & (addr != reg_status);
  assign pslverr = access & (~mapped | (pwrite & (addr == reg_status)));
  assign prdata  = (access & ~pwrite) ? rd_data : '0;

  // ======================================================================
  // register writes, taken at the end of the access cycle
  // ======================================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      drive_q     <= '0;
      steer_q     <= '0;
      light_q     <= '0;
      led_q       <= '0;
      reset_req_q <= '0;
    end
    else if (wr_ok)
    begin
      case (addr)
        reg_drive:     drive_q     <= pwdata[pwm_w-1:0];   // truncated
        reg_steer:     steer_q     <= pwdata[pwm_w-1:0];
        reg_light:     light_q     <= pwdata[light_w-1:0];
        reg_led:       led_q       <= pwdata[led_w-1:0];
        reg_reset_req: reset_req_q <= pwdata[reset_req_w-1:0];
        default:       ;
      endcase
    end
  end

  // out to consumers
  assign ctrl.drive_duty  = drive_q;
  assign ctrl.steer_duty  = steer_q;
  assign ctrl.lighting    = light_q;
  assign ctrl.led_pattern = led_q;
  assign ctrl.reset_req   = reset_req_q;

endmodule

`default_nettype wire

//--- verilog/garfield_pkg.sv
// garfield shared definitions
`default_nettype none

package garfield_pkg;

  // ======================================================================
  // bus and field widths
  // ======================================================================
  parameter int apb_addr_w  = 8;   // byte address
  parameter int apb_data_w  = 32;
  parameter int pwm_w       = 16;  // duty / period values
  parameter int light_w     = 4;   // lighting outputs
  parameter int led_w       = 7;   // register driven leds, led[0] is heartbeat
  parameter int key_w       = 2;   // push keys, active low
  parameter int sw_w        = 4;   // dip switches
  parameter int reset_req_w = 3;   // 0 cold, 1 warm, 2 debug

  // hps reset request pulse lengths in clocks
  parameter int cold_pulse_cycles  = 6;
  parameter int warm_pulse_cycles  = 2;
  parameter int debug_pulse_cycles = 32;

  // ======================================================================
  // register map
  // ======================================================================
  typedef enum logic [apb_addr_w-1:0] {
    reg_drive     = 8'h00,  // drive servo duty
    reg_steer     = 8'h04,  // steering servo duty
    reg_light     = 8'h08,  // lighting bits
    reg_led       = 8'h0C,  // led[7:1] pattern
    reg_status    = 8'h10,  // read only, {sw, keys}
    reg_reset_req = 8'h14   // hps reset requests
  } reg_addr_e;

endpackage

`default_nettype wire

//--- verilog/garfield_top.sv
// garfield fpga control top
`timescale 1ns/10ps
`default_nettype none

module garfield_top #(
  parameter int DEBOUNCE_CYCLES  = 50000,     // 1 ms at 50 MHz
  parameter int HEARTBEAT_CYCLES = 25000000,  // 0.5 s half period
  parameter int PWM_PERIOD       = 50000      // 1 kHz servo frame
) (
  input  logic                                fpga_clk_50,
  input  logic                                hps_fpga_reset_n,
  // apb slave
  input  logic [garfield_pkg::apb_addr_w-1:0] paddr,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [garfield_pkg::apb_data_w-1:0] pwdata,
  output logic [garfield_pkg::apb_data_w-1:0] prdata,
  output logic                                pslverr,
  // board inputs
  input  logic [garfield_pkg::key_w-1:0]      key,
  input  logic [garfield_pkg::sw_w-1:0]       sw,
  // board outputs
  output logic                                drive_pwm,
  output logic                                steering_pwm,
  output logic [garfield_pkg::light_w-1:0]    lighting,
  output logic [garfield_pkg::led_w:0]        led,
  output logic                                hps_cold_reset,
  output logic                                hps_warm_reset,
  output logic                                hps_debug_reset
);
  import garfield_pkg::*;

  logic [key_w-1:0] keys_db;  // debounced, still active low

  vehicle_ctrl_if ctrl_if ();

  // ======================================================================
  // register file and key input
  // ======================================================================
  apb_regs regs_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .paddr            (paddr),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .pwdata           (pwdata),
    .keys_db          (keys_db),
    .sw               (sw),
    .prdata           (prdata),
    .pslverr          (pslverr),
    .ctrl             (ctrl_if.regs)
  );

  key_debounce #(
    .WIDTH           (key_w),
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) debounce_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key_raw          (key),
    .key_db           (keys_db)
  );

  // ======================================================================
  // hps reset request pulses
  // ======================================================================
  reset_pulse_gen #(.PULSE_EXT(cold_pulse_cycles)) cold_pulse_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (ctrl_if.reset_req[0]),
    .pulse            (hps_cold_reset)
  );

  reset_pulse_gen #(.PULSE_EXT(warm_pulse_cycles)) warm_pulse_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (ctrl_if.reset_req[1]),
    .pulse            (hps_warm_reset)
  );

  reset_pulse_gen #(.PULSE_EXT(debug_pulse_cycles)) debug_pulse_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (ctrl_if.reset_req[2]),
    .pulse            (hps_debug_reset)
  );

  // servo channels
  servo_pwm #(.PWM_PERIOD(PWM_PERIOD)) drive_pwm_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .duty             (ctrl_if.drive_duty),
    .pwm              (drive_pwm)
  );

  servo_pwm #(.PWM_PERIOD(PWM_PERIOD)) steer_pwm_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .duty             (ctrl_if.steer_duty),
    .pwm              (steering_pwm)
  );

  status_led_driver #(.HEARTBEAT_CYCLES(HEARTBEAT_CYCLES)) led_drv_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .ctrl             (ctrl_if.sink),
    .led              (led),
    .lighting         (lighting)
  );

endmodule

`default_nettype wire

//--- verilog/key_debounce.sv
// push key debouncer
`timescale 1ns/10ps
`default_nettype none

module key_debounce #(
  parameter int WIDTH           = 2,
  parameter int DEBOUNCE_CYCLES = 50000  // stable clocks before accepting
) (
  input  logic             fpga_clk_50,
  input  logic             hps_fpga_reset_n,
  input  logic [WIDTH-1:0] key_raw,
  output logic [WIDTH-1:0] key_db
);

  localparam int cnt_w = $clog2(DEBOUNCE_CYCLES + 1);

  logic [cnt_w-1:0] stable_cnt [WIDTH];  // one per key

  // count clocks the raw level differs from the accepted one
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_db <= '1;  // keys released
      for (int i = 0; i < WIDTH; i++)
        stable_cnt[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < WIDTH; i++)
      begin
        if (key_raw[i] == key_db[i])
          stable_cnt[i] <= '0;                         // bounce restarts count
        else if (stable_cnt[i] == cnt_w'(DEBOUNCE_CYCLES - 1))
        begin
          key_db[i]     <= key_raw[i];                 // held long enough
          stable_cnt[i] <= '0;
        end
        else
          stable_cnt[i] <= stable_cnt[i] + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/reset_pulse_gen.sv
// reset request pulse stretcher
`timescale 1ns/10ps
`default_nettype none

module reset_pulse_gen #(
  parameter int PULSE_EXT = 6  // pulse length in clocks
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic req,
  output logic pulse
);

  localparam int cnt_w = $clog2(PULSE_EXT) + 1;

  logic             req_q;   // previous request level
  logic             rise;
  logic             busy;    // pulse in progress, blocks retrigger
  logic [cnt_w-1:0] remain;  // clocks left after this one

  assign rise  = req & ~req_q;
  assign pulse = busy;

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      req_q  <= 1'b0;
      busy   <= 1'b0;
      remain <= '0;
    end
    else
    begin
      req_q <= req;
      if (busy)
      begin
        if (remain == '0)
          busy <= 1'b0;            // last pulse clock
        else
          remain <= remain - 1'b1;
      end
      else if (rise)
      begin
        busy   <= 1'b1;
        remain <= cnt_w'(PULSE_EXT - 1);
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/servo_pwm.sv
// servo pwm channel
`timescale 1ns/10ps
`default_nettype none

module servo_pwm #(
  parameter int PWM_PERIOD = 50000  // clocks per frame
) (
  input  logic                           fpga_clk_50,
  input  logic                           hps_fpga_reset_n,
  input  logic [garfield_pkg::pwm_w-1:0] duty,
  output logic                           pwm
);

  localparam int cnt_w = $clog2(PWM_PERIOD);

  logic [cnt_w-1:0] period_cnt;  // free running 0 .. PWM_PERIOD-1

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      period_cnt <= '0;
      pwm        <= 1'b0;
    end
    else
    begin
      if (period_cnt == cnt_w'(PWM_PERIOD - 1))
        period_cnt <= '0;  // wrap at frame end
      else
        period_cnt <= period_cnt + 1'b1;
      // old count, so high time is exactly duty clocks
      pwm <= (32'(period_cnt) < 32'(duty));  // duty >= period gives solid high
    end
  end

endmodule

`default_nettype wire

//--- verilog/status_led_driver.sv
// board led and lighting outputs
`timescale 1ns/10ps
`default_nettype none

module status_led_driver #(
  parameter int HEARTBEAT_CYCLES = 25000000  // clocks per led[0] toggle
) (
  input  logic                             fpga_clk_50,
  input  logic                             hps_fpga_reset_n,
  vehicle_ctrl_if.sink                     ctrl,
  output logic [garfield_pkg::led_w:0]     led,
  output logic [garfield_pkg::light_w-1:0] lighting
);

  localparam int hb_w = $clog2(HEARTBEAT_CYCLES);

  logic [hb_w-1:0] hb_cnt;
  logic            hb_level;  // heartbeat led

  // clock divider for the heartbeat, lamps registered alongside
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      hb_cnt   <= '0;
      hb_level <= 1'b0;
      lighting <= '0;
    end
    else
    begin
      lighting <= ctrl.lighting;  // one clock behind the register
      if (hb_cnt == hb_w'(HEARTBEAT_CYCLES - 1))
      begin
        hb_cnt   <= '0;
        hb_level <= ~hb_level;
      end
      else
        hb_cnt <= hb_cnt + 1'b1;
    end
  end

  assign led = {ctrl.led_pattern, hb_level};  // pattern on 7:1

endmodule

`default_nettype wire

//--- verilog/vehicle_ctrl_if.sv
// vehicle control register bundle
`timescale 1ns/10ps
`default_nettype none

interface vehicle_ctrl_if;
  import garfield_pkg::*;

  logic [pwm_w-1:0]       drive_duty;   // drive servo
  logic [pwm_w-1:0]       steer_duty;   // steering servo
  logic [light_w-1:0]     lighting;     // head/tail/indicator lamps
  logic [led_w-1:0]       led_pattern;  // board leds 7:1
  logic [reset_req_w-1:0] reset_req;    // level requests, edge triggers pulse

  // register file side
  modport regs (
    output drive_duty, steer_duty, lighting, led_pattern, reset_req
  );

  // consumers
  modport sink (
    input drive_duty, steer_duty, lighting, led_pattern, reset_req
  );

endinterface

`default_nettype wire
